//--- design/mem_pkg.sv
package mem_pkg;

    localparam int xlen         = 32;
    localparam int xbytes       = xlen / 8;                  // byte lanes per word
    localparam int dmem_words   = 256;
    localparam int dmem_aw      = $clog2(dmem_words);        // word index bits
    localparam int dmem_latency = 2;                         // read request to rvalid

    // instruction class seen by the memory stage
    typedef enum logic [1:0] {
        mem_none  = 2'd0,                                    // alu result only
        mem_load  = 2'd1,
        mem_store = 2'd2
    } mem_kind_e;

    // funct3 encoding of loads and stores
    typedef enum logic [2:0] {
        width_b  = 3'b000,
        width_h  = 3'b001,
        width_w  = 3'b010,
        width_bu = 3'b100,
        width_hu = 3'b101
    } mem_width_e;

endpackage

//--- design/dmem_if.sv
interface dmem_if
    import mem_pkg::*;
();

    logic              req_ren;                              // one-cycle pulse
    logic              req_wen;                              // one-cycle pulse
    logic [xlen-1:0]   req_addr;
    logic [xlen-1:0]   req_wdata;
    logic [xbytes-1:0] req_wstrb;
    logic [xlen-1:0]   rsp_rdata;
    logic              rsp_rvalid;

    modport requester (
        output req_ren, req_wen, req_addr, req_wdata, req_wstrb,
        input  rsp_rdata, rsp_rvalid
    );

    modport responder (
        input  req_ren, req_wen, req_addr, req_wdata, req_wstrb,
        output rsp_rdata, rsp_rvalid
    );

endinterface

//--- design/load_align.sv
module load_align
    import mem_pkg::*;
(
    input  logic [xlen-1:0] word,
    input  logic [1:0]      offset,
    input  mem_width_e      width,
    output logic [xlen-1:0] data
);

    logic [7:0]  byte_sel;
    logic [15:0] half_sel;

    assign byte_sel = word[{offset, 3'b000} +: 8];
    assign half_sel = offset[1] ? word[31:16] : word[15:0];   // aligned halves only

    always_comb begin
        case (width)
            width_b:  data = {{(xlen-8){byte_sel[7]}}, byte_sel};
            width_h:  data = {{(xlen-16){half_sel[15]}}, half_sel};
            width_bu: data = {{(xlen-8){1'b0}}, byte_sel};
            width_hu: data = {{(xlen-16){1'b0}}, half_sel};
            width_w:  data = word;
            default:  data = word;
        endcase
    end

endmodule

//--- design/store_align.sv
module store_align
    import mem_pkg::*;
(
    input  logic [xlen-1:0]   data,
    input  logic [1:0]        offset,
    input  mem_width_e        width,
    output logic [xlen-1:0]   wdata,
    output logic [xbytes-1:0] wstrb
);

    always_comb begin
        case (width)
            width_b: begin
                wdata = {xbytes{data[7:0]}};                 // every lane, strobe picks one
                wstrb = 4'b0001 << offset;
            end
            width_h: begin
                wdata = {2{data[15:0]}};
                wstrb = offset[1] ? 4'b1100 : 4'b0011;
            end
            width_w: begin
                wdata = data;
                wstrb = 4'b1111;
            end
            default: begin
                wdata = data;
                wstrb = 4'b0000;                             // unsigned widths never store
            end
        endcase
    end

endmodule

//--- design/mem_stage.sv
module mem_stage
    import mem_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,

    input  logic             in_valid,
    output logic             in_ready,
    input  mem_kind_e        in_kind,
    input  mem_width_e       in_width,
    input  logic [xlen-1:0]  in_alu_result,
    input  logic [xlen-1:0]  in_store_data,
    input  logic [xlen-1:0]  in_pc,
    input  logic [4:0]       in_rd,
    input  logic             in_rd_wen,

    output logic             out_valid,
    input  logic             out_ready,
    output logic [xlen-1:0]  out_pc,
    output logic [4:0]       out_rd,
    output logic             out_rd_wen,
    output logic [xlen-1:0]  out_wb_data,

    dmem_if.requester        dmem
);

    typedef enum logic [1:0] {
        st_idle,
        st_issue,
        st_wait_read,
        st_hold
    } state_e;

    state_e          state;
    mem_kind_e       kind_q;
    mem_width_e      width_q;
    logic [xlen-1:0] addr_q;
    logic [xlen-1:0] store_q;
    logic [xlen-1:0] pc_q;
    logic [4:0]      rd_q;
    logic            rd_wen_q;
    logic [xlen-1:0] wb_q;
    logic [xlen-1:0] load_data;
    logic            accept;
    logic            load_done;

    assign in_ready  = (state == st_idle);                   // empty stage only
    assign out_valid = (state == st_hold);
    assign accept    = in_valid && in_ready;
    assign load_done = (state == st_wait_read) && dmem.rsp_rvalid;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle:      if (accept) state <= st_issue;
                st_issue:     state <= (kind_q == mem_load) ? st_wait_read : st_hold;
                st_wait_read: if (dmem.rsp_rvalid) state <= st_hold;
                st_hold:      if (out_ready) state <= st_idle;
                default:      state <= st_idle;
            endcase
        end
    end

    // capture register, payload only
    always_ff @(posedge clk) begin
        if (accept) begin
            kind_q   <= in_kind;
            width_q  <= in_width;
            addr_q   <= in_alu_result;
            store_q  <= in_store_data;
            pc_q     <= in_pc;
            rd_q     <= in_rd;
            rd_wen_q <= in_rd_wen;
        end
    end

    // writeback value: alu result unless a load replaces it
    always_ff @(posedge clk) begin
        if (accept) begin
            wb_q <= in_alu_result;
        end else if (load_done) begin
            wb_q <= load_data;
        end
    end

    assign dmem.req_ren  = (state == st_issue) && (kind_q == mem_load);
    assign dmem.req_wen  = (state == st_issue) && (kind_q == mem_store);
    assign dmem.req_addr = addr_q;

    store_align u_store_align (
        .data   (store_q),
        .offset (addr_q[1:0]),
        .width  (width_q),
        .wdata  (dmem.req_wdata),
        .wstrb  (dmem.req_wstrb)
    );

    load_align u_load_align (
        .word   (dmem.rsp_rdata),
        .offset (addr_q[1:0]),
        .width  (width_q),
        .data   (load_data)
    );

    assign out_pc      = pc_q;
    assign out_rd      = rd_q;
    assign out_rd_wen  = rd_wen_q;
    assign out_wb_data = wb_q;

endmodule

//--- design/data_sram.sv
module data_sram
    import mem_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    dmem_if.responder dmem
);

    logic [xlen-1:0]         mem [dmem_words];
    logic [dmem_aw-1:0]      idx;
    logic [dmem_latency-1:0] vld_pipe;
    logic [xlen-1:0]         data_pipe [dmem_latency];

    assign idx = dmem.req_addr[dmem_aw+1:2];                 // upper bits wrap

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < dmem_words; i++) begin
                mem[i] <= '0;
            end
        end else if (dmem.req_wen) begin
            for (int b = 0; b < xbytes; b++) begin
                if (dmem.req_wstrb[b]) begin
                    mem[idx][8*b +: 8] <= dmem.req_wdata[8*b +: 8];
                end
            end
        end
    end

    // valid shift chain
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vld_pipe <= '0;
        end else begin
            vld_pipe[0] <= dmem.req_ren;
            for (int i = 1; i < dmem_latency; i++) begin
                vld_pipe[i] <= vld_pipe[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dmem.req_ren) begin
            data_pipe[0] <= mem[idx];
        end
        for (int i = 1; i < dmem_latency; i++) begin
            data_pipe[i] <= data_pipe[i-1];
        end
    end

    assign dmem.rsp_rvalid = vld_pipe[dmem_latency-1];
    assign dmem.rsp_rdata  = data_pipe[dmem_latency-1];

endmodule

//--- design/mem_top.sv
module mem_top
    import mem_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,

    input  logic             in_valid,
    output logic             in_ready,
    input  mem_kind_e        in_kind,
    input  mem_width_e       in_width,
    input  logic [xlen-1:0]  in_alu_result,
    input  logic [xlen-1:0]  in_store_data,
    input  logic [xlen-1:0]  in_pc,
    input  logic [4:0]       in_rd,
    input  logic             in_rd_wen,

    output logic             out_valid,
    input  logic             out_ready,
    output logic [xlen-1:0]  out_pc,
    output logic [4:0]       out_rd,
    output logic             out_rd_wen,
    output logic [xlen-1:0]  out_wb_data
);

    dmem_if dmem ();

    mem_stage u_mem_stage (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .in_kind       (in_kind),
        .in_width      (in_width),
        .in_alu_result (in_alu_result),
        .in_store_data (in_store_data),
        .in_pc         (in_pc),
        .in_rd         (in_rd),
        .in_rd_wen     (in_rd_wen),
        .out_valid     (out_valid),
        .out_ready     (out_ready),
        .out_pc        (out_pc),
        .out_rd        (out_rd),
        .out_rd_wen    (out_rd_wen),
        .out_wb_data   (out_wb_data),
        .dmem          (dmem.requester)
    );

    data_sram u_data_sram (
        .clk   (clk),
        .rst_n (rst_n),
        .dmem  (dmem.responder)
    );

endmodule

//--- bench/mem_assertions.sv
module mem_assertions
    import mem_pkg::*;
(
    input logic            clk,
    input logic            rst_n,
    input logic            in_valid,
    input logic            in_ready,
    input mem_kind_e       in_kind,
    input mem_width_e      in_width,
    input logic [xlen-1:0] in_alu_result,
    input logic            out_valid,
    input logic            out_ready,
    input logic [xlen-1:0] out_pc,
    input logic [4:0]      out_rd,
    input logic            out_rd_wen,
    input logic [xlen-1:0] out_wb_data,
    input logic            req_ren,
    input logic            req_wen
);

    timeunit 1ns;
    timeprecision 100ps;

    logic misaligned;

    always_comb begin
        case (in_width)
            width_h, width_hu: misaligned = in_alu_result[0];
            width_w:           misaligned = |in_alu_result[1:0];
            default:           misaligned = 1'b0;       // bytes fit anywhere
        endcase
    end

    a_one_side: assert property (@(posedge clk) disable iff (!rst_n)
        !(in_ready && out_valid)) else $error("in_ready and out_valid high together");

    a_hold: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_wb_data) && $stable(out_pc)
            && $stable(out_rd) && $stable(out_rd_wen))
        else $error("result changed while stalled");

    a_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid && in_ready && in_kind != mem_none |-> !misaligned)
        else $error("misaligned memory access accepted");

    a_ren_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        req_ren |=> !req_ren) else $error("read request longer than one cycle");

    a_wen_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        req_wen |=> !req_wen) else $error("write request longer than one cycle");

endmodule

//--- bench/mem_tb.sv
module mem_tb
    import mem_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    logic            clk;
    logic            rst_n;
    logic            in_valid;
    logic            in_ready;
    mem_kind_e       in_kind;
    mem_width_e      in_width;
    logic [xlen-1:0] in_alu_result;
    logic [xlen-1:0] in_store_data;
    logic [xlen-1:0] in_pc;
    logic [4:0]      in_rd;
    logic            in_rd_wen;
    logic            out_valid;
    logic            out_ready;
    logic [xlen-1:0] out_pc;
    logic [4:0]      out_rd;
    logic            out_rd_wen;
    logic [xlen-1:0] out_wb_data;

    logic [xlen-1:0] shadow [dmem_words];                // expected memory contents
    logic [31:0]     seed = 32'hb428;

    mem_top dut (.*);

    bind mem_stage mem_assertions u_mem_assertions (
        .clk (clk), .rst_n (rst_n),
        .in_valid (in_valid), .in_ready (in_ready), .in_kind (in_kind),
        .in_width (in_width), .in_alu_result (in_alu_result),
        .out_valid (out_valid), .out_ready (out_ready), .out_pc (out_pc),
        .out_rd (out_rd), .out_rd_wen (out_rd_wen), .out_wb_data (out_wb_data),
        .req_ren (dmem.req_ren), .req_wen (dmem.req_wen)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] xorshift();
        seed ^= seed << 13;
        seed ^= seed >> 17;
        seed ^= seed << 5;
        return seed;
    endfunction

    // pick the lane, then extend per funct3
    function automatic logic [xlen-1:0] expect_load(input logic [xlen-1:0] word,
                                                    input logic [1:0] off,
                                                    input mem_width_e width);
        logic [xlen-1:0] sh;
        sh = word >> (8 * off);
        case (width)
            width_b:  return {{(xlen-8){sh[7]}}, sh[7:0]};
            width_h:  return {{(xlen-16){sh[15]}}, sh[15:0]};
            width_bu: return {{(xlen-8){1'b0}}, sh[7:0]};
            width_hu: return {{(xlen-16){1'b0}}, sh[15:0]};
            default:  return word;
        endcase
    endfunction

    task automatic apply_store(input logic [xlen-1:0] addr, input logic [xlen-1:0] data,
                               input mem_width_e width);
        int nbytes;
        int lane;
        nbytes = (width == width_b) ? 1 : (width == width_h) ? 2 : 4;
        for (int j = 0; j < nbytes; j++) begin
            lane = int'(addr[1:0]) + j;
            shadow[addr[dmem_aw+1:2]][8*lane +: 8] = data[8*j +: 8];
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_word(input string name, input logic [xlen-1:0] expected,
                              input logic [xlen-1:0] actual);
        if (actual !== expected)
            abort_run($sformatf("[ERROR] %s: expected %08h, actual %08h", name, expected, actual));
    endtask

    task automatic check_rd(input string name, input logic [4:0] expected,
                            input logic [4:0] actual);
        if (actual !== expected)
            abort_run($sformatf("[ERROR] %s: expected x%0d, actual x%0d", name, expected, actual));
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected)
            abort_run($sformatf("[ERROR] %s: expected %0b, actual %0b", name, expected, actual));
    endtask

    task automatic check_latency(input string name, input int expected, input int actual);
        if (actual != expected)
            abort_run($sformatf("[ERROR] %s latency: expected %0d, actual %0d", name, expected,
                                actual));
    endtask

    task automatic send_one(input int n);
        mem_kind_e       kind;
        mem_width_e      width;
        logic [31:0]     r;
        logic [1:0]      off;
        logic [xlen-1:0] addr;
        logic [xlen-1:0] sdata;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] exp_wb;
        logic [4:0]      rd;
        logic            rd_wen;
        string           name;
        int              waited;
        bit              seen;
        bit              done;

        r = xorshift();
        kind = (r % 32'd5 == 32'd0) ? mem_none : (r[8] ? mem_load : mem_store);
        case (r[31:16] % (kind == mem_store ? 16'd3 : 16'd5))
            16'd0:   width = width_b;
            16'd1:   width = width_h;
            16'd2:   width = width_w;
            16'd3:   width = width_bu;
            default: width = width_hu;
        endcase
        r = xorshift();
        case (width)
            width_w:           off = 2'b00;
            width_h, width_hu: off = {r[9], 1'b0};
            default:           off = r[9:8];
        endcase
        addr = (kind == mem_none) ? xorshift() : {24'd0, r[15:10], off};   // 64-word window
        sdata = xorshift();
        pc = xorshift();
        r = xorshift();
        rd = r[4:0];
        rd_wen = r[5];
        name = $sformatf("%s %s #%0d", kind.name(), width.name(), n);

        repeat (xorshift() % 32'd3) @(posedge clk);
        in_valid      <= 1'b1;
        in_kind       <= kind;
        in_width      <= width;
        in_alu_result <= addr;
        in_store_data <= sdata;
        in_pc         <= pc;
        in_rd         <= rd;
        in_rd_wen     <= rd_wen;

        waited = 0;
        do begin
            @(posedge clk);
            check_flag({name, " stray out_valid"}, 1'b0, out_valid);
            waited++;
            if (!in_ready && waited >= 50)
                abort_run($sformatf("timeout: %s not accepted within 50 cycles", name));
        end while (!in_ready);
        in_valid <= 1'b0;

        exp_wb = addr;
        if (kind == mem_store)
            apply_store(addr, sdata, width);
        else if (kind == mem_load)
            exp_wb = expect_load(shadow[addr[dmem_aw+1:2]], off, width);

        waited = 0;
        seen   = 1'b0;
        do begin
            @(posedge clk);
            waited++;
            if (out_valid) begin
                if (!seen)
                    check_latency(name, (kind == mem_load) ? dmem_latency + 1 : 1, waited - 1);
                seen = 1'b1;
                check_word({name, " wb_data"}, exp_wb, out_wb_data);
                check_word({name, " pc"}, pc, out_pc);
                check_rd({name, " rd"}, rd, out_rd);
                check_flag({name, " rd_wen"}, rd_wen, out_rd_wen);
            end
            done = out_valid && out_ready;
            if (!done && waited >= 50)
                abort_run($sformatf("timeout: no result for %s within 50 cycles", name));
            out_ready <= (xorshift() % 32'd4) != 32'd0;   // stall about one cycle in four
        end while (!done);
    endtask

    initial begin
        for (int i = 0; i < dmem_words; i++) begin
            shadow[i] = '0;
        end
        rst_n         <= 1'b0;
        in_valid      <= 1'b0;
        in_kind       <= mem_none;
        in_width      <= width_w;
        in_alu_result <= '0;
        in_store_data <= '0;
        in_pc         <= '0;
        in_rd         <= '0;
        in_rd_wen     <= 1'b0;
        out_ready     <= 1'b1;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        check_flag("reset in_ready", 1'b1, in_ready);
        check_flag("reset out_valid", 1'b0, out_valid);
        for (int n = 0; n < 400; n++) begin
            send_one(n);
        end
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

//--- flist.f
design/mem_pkg.sv
design/dmem_if.sv
design/load_align.sv
design/store_align.sv
design/mem_stage.sv
design/data_sram.sv
design/mem_top.sv
bench/mem_assertions.sv
bench/mem_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module mem_tb -f flist.f -o mem_sim &&
./obj_dir/mem_sim || exit 1
